// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_dsp_router
FILELIST := dsp_router.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST)) testbench/tb_axil_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/dsp_pkg.sv
// dsp routing hub
// shared widths and types

package dsp_pkg;

   // sample and select widths
   localparam int DATA_W      = 14;            // adc / dac sample
   localparam int SEL_W       = 4;             // source number
   localparam int SUM_W       = DATA_W + SEL_W; // 16 leaves of headroom
   localparam int TREE_LEAVES = 16;            // adder tree inputs, power of two

   // host bus geometry
   localparam int AXIL_AW = 20;
   localparam int AXIL_DW = 32;
   localparam int TGT_LSB = 16;                // target number sits above the offset

   typedef logic signed [DATA_W-1:0] sample_t;
   typedef logic [SEL_W-1:0]         sel_t;

   localparam sel_t SEL_NONE = sel_t'(15);     // routes zero

   // per-output dac enable
   typedef struct packed {
      logic to_dac_b;
      logic to_dac_a;                          // bit 0
   } dac_mask_t;

   // register offsets inside each target window
   typedef enum logic [15:0] {
      REG_INPUT_SEL  = 16'h0000,
      REG_OUTPUT_SEL = 16'h0004,
      REG_SAT_STATUS = 16'h0008,
      REG_SYNC       = 16'h000C,
      REG_SIGNAL_MON = 16'h0010
   } reg_off_e;

   // host to slave channels
   typedef struct packed {
      logic               awvalid;
      logic [AXIL_AW-1:0] awaddr;
      logic               wvalid;
      logic [AXIL_DW-1:0] wdata;
      logic [3:0]         wstrb;
      logic               bready;
      logic               arvalid;
      logic [AXIL_AW-1:0] araddr;
      logic               rready;
   } axil_req_t;

   // slave to host channels
   typedef struct packed {
      logic               awready;
      logic               wready;
      logic               bvalid;
      logic [1:0]         bresp;
      logic               arready;
      logic               rvalid;
      logic [AXIL_DW-1:0] rdata;
      logic [1:0]         rresp;
   } axil_rsp_t;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } axil_resp_e;

endpackage

// File: design/dsp_router_top.sv
// laser servo routing core

module dsp_router_top import dsp_pkg::*; #(
   parameter int NUM_SLOTS = 8
) (
   input  logic                    clk_i,
   input  logic                    rstn_i,
   input  sample_t                 adc_a_i,
   input  sample_t                 adc_b_i,
   input  sample_t                 asg1_i,
   input  sample_t                 asg2_i,
   input  sample_t [NUM_SLOTS-1:0] slot_signal_i,  // routed outputs of the slots
   input  sample_t [NUM_SLOTS-1:0] slot_direct_i,  // summed into the dacs
   input  axil_req_t               axil_req_i,
   output sample_t                 dac_a_o,
   output sample_t                 dac_b_o,
   output sample_t                 scope1_o,
   output sample_t                 scope2_o,
   output sample_t                 pwm0_o,
   output sample_t                 pwm1_o,
   output sample_t [NUM_SLOTS-1:0] slot_in_o,
   output logic    [NUM_SLOTS-1:0] slot_sync_o,
   output axil_rsp_t               axil_rsp_o
);

   sel_t      [NUM_SLOTS+3:0] route_sel;   // per tap source number
   dac_mask_t [NUM_SLOTS+1:0] dac_mask;    // per direct output
   sel_t                      mon_sel;
   sample_t                   mon_val;
   logic      [1:0]           dac_sat;

   signal_router #(.NUM_SLOTS(NUM_SLOTS)) signal_router_inst (
      .slot_signal_i (slot_signal_i),
      .asg1_i        (asg1_i),
      .asg2_i        (asg2_i),
      .adc_a_i       (adc_a_i),
      .adc_b_i       (adc_b_i),
      .dac_a_i       (dac_a_o),             // dac feedback as sources
      .dac_b_i       (dac_b_o),
      .sel_i         (route_sel),
      .mon_sel_i     (mon_sel),
      .slot_in_o     (slot_in_o),
      .scope1_o      (scope1_o),
      .scope2_o      (scope2_o),
      .pwm0_o        (pwm0_o),
      .pwm1_o        (pwm1_o),
      .mon_o         (mon_val)
   );

   output_summer #(.NUM_SLOTS(NUM_SLOTS)) output_summer_inst (
      .clk_i    (clk_i),
      .rstn_i   (rstn_i),
      .direct_i ({asg2_i, asg1_i, slot_direct_i}),  // generators on top
      .mask_i   (dac_mask),
      .dac_a_o  (dac_a_o),
      .dac_b_o  (dac_b_o),
      .sat_o    (dac_sat)
   );

   routing_regs #(.NUM_SLOTS(NUM_SLOTS)) routing_regs_inst (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .axil_req_i (axil_req_i),
      .sat_i      (dac_sat),
      .mon_i      (mon_val),
      .axil_rsp_o (axil_rsp_o),
      .sel_o      (route_sel),
      .mask_o     (dac_mask),
      .mon_sel_o  (mon_sel),
      .sync_o     (slot_sync_o)
   );

endmodule

// File: design/output_summer.sv
// dac output summation
// masked adder tree with 14 bit clamp

module output_summer import dsp_pkg::*; #(
   parameter int NUM_SLOTS = 8
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  sample_t   [NUM_SLOTS+1:0] direct_i,  // slots first, then asg1, asg2
   input  dac_mask_t [NUM_SLOTS+1:0] mask_i,
   output sample_t                   dac_a_o,
   output sample_t                   dac_b_o,
   output logic      [1:0]           sat_o      // bit 0 dac a, bit 1 dac b
);

   localparam int NUM_IN     = NUM_SLOTS + 2;
   localparam int NUM_PAIRS  = TREE_LEAVES / 2;
   localparam int NUM_NODES  = TREE_LEAVES - 1;  // 8 pairs, then 4, 2, 1

   typedef logic signed [SUM_W-1:0] acc_t;

   // channel 0 is dac a, channel 1 is dac b
   acc_t    [1:0][TREE_LEAVES-1:0] leaf;
   acc_t    [1:0][NUM_NODES-1:0]   node_q;      // pair stage at 0..7, tree above
   acc_t    [1:0]                  sum_q;       // final register
   sample_t [1:0]                  dac;

   function automatic acc_t sext(input sample_t v);
      return {{SEL_W{v[DATA_W-1]}}, v};
   endfunction

   // sign extend, gate per dac, pad to 16 leaves
   for (genvar l = 0; l < TREE_LEAVES; l++) begin : g_leaf
      if (l < NUM_IN) begin : g_used
         assign leaf[0][l] = mask_i[l].to_dac_a ? sext(direct_i[l]) : '0;
         assign leaf[1][l] = mask_i[l].to_dac_b ? sext(direct_i[l]) : '0;
      end else begin : g_pad
         assign leaf[0][l] = '0;                // no source behind this leaf
         assign leaf[1][l] = '0;
      end
   end

   // five stages: pairs, three tree levels, final
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         node_q <= '0;
         sum_q  <= '0;
      end else begin
         for (int c = 0; c < 2; c++) begin
            // pair stage
            for (int p = 0; p < NUM_PAIRS; p++) begin
               node_q[c][p] <= leaf[c][2*p] + leaf[c][2*p+1];
            end
            // tree levels, node n+8 sums nodes 2n and 2n+1
            for (int n = 0; n < NUM_PAIRS - 1; n++) begin
               node_q[c][NUM_PAIRS+n] <= node_q[c][2*n] + node_q[c][2*n+1];
            end
            sum_q[c] <= node_q[c][NUM_NODES-1];  // root of the tree
         end
      end
   end

   // clamp to the 14 bit signed range
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         // upper bits not all equal means out of range
         sat_o[c] = !(&sum_q[c][SUM_W-1:DATA_W-1]) && (|sum_q[c][SUM_W-1:DATA_W-1]);
         if (!sat_o[c]) begin
            dac[c] = sum_q[c][DATA_W-1:0];
         end else if (sum_q[c][SUM_W-1]) begin
            dac[c] = {1'b1, {(DATA_W-1){1'b0}}};  // -8192
         end else begin
            dac[c] = {1'b0, {(DATA_W-1){1'b1}}};  // +8191
         end
      end
   end

   assign dac_a_o = dac[0];
   assign dac_b_o = dac[1];

endmodule

// File: design/routing_regs.sv
// routing register bank
// axi4-lite slave with select, mask and sync registers

module routing_regs import dsp_pkg::*; #(
   parameter int NUM_SLOTS = 8
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  axil_req_t                 axil_req_i,
   input  logic      [1:0]           sat_i,      // live clamp flags
   input  sample_t                   mon_i,      // monitored source value
   output axil_rsp_t                 axil_rsp_o,
   output sel_t      [NUM_SLOTS+3:0] sel_o,
   output dac_mask_t [NUM_SLOTS+1:0] mask_o,
   output sel_t                      mon_sel_o,
   output logic      [NUM_SLOTS-1:0] sync_o
);

   localparam int NUM_SEL  = NUM_SLOTS + 4;      // slots, scope1, scope2, pwm0, pwm1
   localparam int NUM_MASK = NUM_SLOTS + 2;      // slots, asg1, asg2
   localparam int NUM_SRC  = NUM_SLOTS + 6;      // monitor range
   localparam sel_t ADC_A  = sel_t'(NUM_SLOTS + 2);
   localparam sel_t ADC_B  = sel_t'(NUM_SLOTS + 3);

   // register bank
   sel_t      [NUM_SEL-1:0]   sel_q;
   dac_mask_t [NUM_MASK-1:0]  mask_q;
   logic      [NUM_SLOTS-1:0] sync_q;

   // handshake state
   logic               bvalid_q;
   logic               rvalid_q;
   axil_resp_e         bresp_q;
   axil_resp_e         rresp_q;
   logic [AXIL_DW-1:0] rdata_q;

   // decode
   logic               idle;
   logic               wr_acc;
   logic               rd_acc;
   logic               wr_ok;
   logic               rd_ok;
   sel_t               wr_tgt;
   sel_t               rd_tgt;
   reg_off_e           wr_off;
   reg_off_e           rd_off;
   logic [AXIL_DW-1:0] rd_val;

   // legal target per offset
   function automatic logic addr_ok(input reg_off_e off, input sel_t tgt);
      case (off)
         REG_INPUT_SEL:  return int'(tgt) < NUM_SEL;
         REG_OUTPUT_SEL: return int'(tgt) < NUM_MASK;
         REG_SIGNAL_MON: return int'(tgt) < NUM_SRC;
         REG_SAT_STATUS: return 1'b1;            // target not used
         REG_SYNC:       return 1'b1;
         default:        return 1'b0;
      endcase
   endfunction

   assign wr_tgt = axil_req_i.awaddr[AXIL_AW-1:TGT_LSB];
   assign rd_tgt = axil_req_i.araddr[AXIL_AW-1:TGT_LSB];
   assign wr_off = reg_off_e'(axil_req_i.awaddr[TGT_LSB-1:0]);
   assign rd_off = reg_off_e'(axil_req_i.araddr[TGT_LSB-1:0]);
   assign wr_ok  = addr_ok(wr_off, wr_tgt);
   assign rd_ok  = addr_ok(rd_off, rd_tgt);

   // one transaction at a time, write wins
   assign idle   = !bvalid_q && !rvalid_q;
   assign wr_acc = idle && axil_req_i.awvalid && axil_req_i.wvalid;
   assign rd_acc = idle && axil_req_i.arvalid && !(axil_req_i.awvalid || axil_req_i.wvalid);

   // bank with reset defaults
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < NUM_SLOTS; k++) begin
            sel_q[k] <= ADC_A;
         end
         sel_q[NUM_SLOTS]   <= ADC_A;           // scope1
         sel_q[NUM_SLOTS+1] <= ADC_B;           // scope2
         sel_q[NUM_SLOTS+2] <= SEL_NONE;        // pwm off
         sel_q[NUM_SLOTS+3] <= SEL_NONE;
         mask_q <= '0;
         sync_q <= '1;                           // all slots running
      end else if (wr_acc && wr_ok && axil_req_i.wstrb[0]) begin
         case (wr_off)
            REG_INPUT_SEL:  sel_q[wr_tgt]  <= axil_req_i.wdata[SEL_W-1:0];
            REG_OUTPUT_SEL: mask_q[wr_tgt] <= axil_req_i.wdata[1:0];
            REG_SYNC:       sync_q         <= axil_req_i.wdata[NUM_SLOTS-1:0];
            default: ;                           // status and monitor are read only
         endcase
      end
   end

   // read mux, sampled at accept
   always_comb begin
      case (rd_off)
         REG_INPUT_SEL:  rd_val = {{(AXIL_DW-SEL_W){1'b0}}, sel_q[rd_tgt]};
         REG_OUTPUT_SEL: rd_val = {{(AXIL_DW-2){1'b0}}, mask_q[rd_tgt]};
         REG_SAT_STATUS: rd_val = {{(AXIL_DW-2){1'b0}}, sat_i};
         REG_SYNC:       rd_val = {{(AXIL_DW-NUM_SLOTS){1'b0}}, sync_q};
         REG_SIGNAL_MON: rd_val = {{(AXIL_DW-DATA_W){1'b0}}, mon_i};  // zero extended
         default:        rd_val = '0;
      endcase
   end

   // valid flags hold until the host takes them
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_acc) begin
            bvalid_q <= 1'b1;
         end else if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;
         end
         if (rd_acc) begin
            rvalid_q <= 1'b1;
         end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // response payload
   always_ff @(posedge clk_i) begin
      if (wr_acc) begin
         bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_acc) begin
         rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
         rdata_q <= rd_ok ? rd_val : '0;        // bad address reads zero
      end
   end

   always_comb begin
      axil_rsp_o.awready = wr_acc;               // aw and w taken together
      axil_rsp_o.wready  = wr_acc;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.arready = rd_acc;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
   end

   assign sel_o     = sel_q;
   assign mask_o    = mask_q;
   assign sync_o    = sync_q;
   assign mon_sel_o = rd_tgt;                    // router looks up the read target

   // stalled responses stay put
   a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q))
      else $error("routing_regs: bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q))
      else $error("routing_regs: rvalid dropped before rready");

endmodule

// File: design/signal_router.sv
// source select matrix

module signal_router import dsp_pkg::*; #(
   parameter int NUM_SLOTS = 8
) (
   input  sample_t [NUM_SLOTS-1:0] slot_signal_i,  // slot outputs, sources 0..N-1
   input  sample_t                 asg1_i,
   input  sample_t                 asg2_i,
   input  sample_t                 adc_a_i,
   input  sample_t                 adc_b_i,
   input  sample_t                 dac_a_i,        // fed back from the summer
   input  sample_t                 dac_b_i,
   input  sel_t    [NUM_SLOTS+3:0] sel_i,          // slots, scope1, scope2, pwm0, pwm1
   input  sel_t                    mon_sel_i,      // monitor read target
   output sample_t [NUM_SLOTS-1:0] slot_in_o,
   output sample_t                 scope1_o,
   output sample_t                 scope2_o,
   output sample_t                 pwm0_o,
   output sample_t                 pwm1_o,
   output sample_t                 mon_o
);

   // source numbers after the slots
   localparam int SRC_ASG1  = NUM_SLOTS;
   localparam int SRC_ASG2  = NUM_SLOTS + 1;
   localparam int SRC_ADC_A = NUM_SLOTS + 2;
   localparam int SRC_ADC_B = NUM_SLOTS + 3;
   localparam int SRC_DAC_A = NUM_SLOTS + 4;
   localparam int SRC_DAC_B = NUM_SLOTS + 5;

   // tap numbers in the select array
   localparam int TAP_SCOPE1 = NUM_SLOTS;
   localparam int TAP_SCOPE2 = NUM_SLOTS + 1;
   localparam int TAP_PWM0   = NUM_SLOTS + 2;
   localparam int TAP_PWM1   = NUM_SLOTS + 3;

   // one entry per select code
   sample_t [2**SEL_W-1:0] src_tbl;

   // numbered source list
   // codes past the last source stay zero
   always_comb begin
      src_tbl = '0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         src_tbl[k] = slot_signal_i[k];
      end
      src_tbl[SRC_ASG1]  = asg1_i;
      src_tbl[SRC_ASG2]  = asg2_i;
      src_tbl[SRC_ADC_A] = adc_a_i;
      src_tbl[SRC_ADC_B] = adc_b_i;
      src_tbl[SRC_DAC_A] = dac_a_i;
      src_tbl[SRC_DAC_B] = dac_b_i;
      src_tbl[SEL_NONE]  = '0;          // none code always reads zero
   end

   // slot inputs
   always_comb begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
         slot_in_o[k] = src_tbl[sel_i[k]];
      end
   end

   // scope and pwm taps, all combinational
   assign scope1_o = src_tbl[sel_i[TAP_SCOPE1]];
   assign scope2_o = src_tbl[sel_i[TAP_SCOPE2]];
   assign pwm0_o   = src_tbl[sel_i[TAP_PWM0]];
   assign pwm1_o   = src_tbl[sel_i[TAP_PWM1]];

   // live value for the monitor register
   assign mon_o = src_tbl[mon_sel_i];

endmodule

// File: dsp_router.f
+incdir+testbench
design/dsp_pkg.sv
design/signal_router.sv
design/output_summer.sv
design/routing_regs.sv
design/dsp_router_top.sv
testbench/tb_dsp_router.sv

// File: testbench/tb_axil_tasks.svh
// axi4-lite host tasks
// reference model lookups for the register bank

function automatic logic [19:0] reg_addr(input int tgt, input logic [15:0] off);
   return {4'(tgt), off};                       // target above the offset
endfunction

function automatic logic is_clamped(input int v);
   return (v > 8191) || (v < -8192);
endfunction

function automatic sample_t clamp_sample(input int v);
   if (v > 8191) begin
      return sample_t'(8191);
   end
   if (v < -8192) begin
      return sample_t'(-8192);
   end
   return sample_t'(v);
endfunction

// okay only for a known offset with its target in range
function automatic logic [1:0] expected_resp(input logic [19:0] addr);
   int tgt;
   tgt = int'(addr[19:16]);
   case (addr[15:0])
      REG_INPUT_SEL:  return (tgt < NUM_TAPS) ? RESP_OKAY : RESP_SLVERR;
      REG_OUTPUT_SEL: return (tgt < NS + 2) ? RESP_OKAY : RESP_SLVERR;
      REG_SIGNAL_MON: return (tgt < NS + 6) ? RESP_OKAY : RESP_SLVERR;
      REG_SAT_STATUS: return RESP_OKAY;          // target ignored
      REG_SYNC:       return RESP_OKAY;
      default:        return RESP_SLVERR;
   endcase
endfunction

function automatic logic [31:0] expected_rdata(input logic [19:0] addr);
   int tgt;
   tgt = int'(addr[19:16]);
   if (expected_resp(addr) != RESP_OKAY) begin
      return '0;                                 // rejected reads give zero
   end
   case (addr[15:0])
      REG_INPUT_SEL:  return 32'(m_sel[tgt]);
      REG_OUTPUT_SEL: return 32'(m_mask[tgt]);
      REG_SAT_STATUS: return {30'b0, is_clamped(pipe_b[4]), is_clamped(pipe_a[4])};
      REG_SYNC:       return 32'(m_sync);
      default:        return {18'b0, exp_src[tgt]};  // live source, zero extended
   endcase
endfunction

// aw and w together, then hold bready low for stall cycles
task automatic axil_write(input logic [19:0] addr, input logic [31:0] data, input int stall);
   req.awvalid <= 1'b1;
   req.awaddr  <= addr;
   req.wvalid  <= 1'b1;
   req.wdata   <= data;
   req.wstrb   <= 4'hF;
   do begin
      @(posedge clk_i);
   end while (!rsp.awready);
   exp_bresp = expected_resp(addr);             // accepted at this edge
   if (exp_bresp == RESP_OKAY) begin
      case (addr[15:0])
         REG_INPUT_SEL:  m_sel[addr[19:16]]  <= data[3:0];
         REG_OUTPUT_SEL: m_mask[addr[19:16]] <= data[1:0];
         REG_SYNC:       m_sync              <= data[NS-1:0];
         default: ;
      endcase
   end
   req.awvalid <= 1'b0;
   req.wvalid  <= 1'b0;
   repeat (stall) @(posedge clk_i);
   req.bready <= 1'b1;
   do begin
      @(posedge clk_i);
   end while (!rsp.bvalid);
   req.bready <= 1'b0;
endtask

task automatic axil_read(input logic [19:0] addr, input int stall);
   req.arvalid <= 1'b1;
   req.araddr  <= addr;
   do begin
      @(posedge clk_i);
   end while (!rsp.arready);
   exp_rresp = expected_resp(addr);
   exp_rdata = expected_rdata(addr);            // values seen at accept
   req.arvalid <= 1'b0;
   repeat (stall) @(posedge clk_i);
   req.rready <= 1'b1;
   do begin
      @(posedge clk_i);
   end while (!rsp.rvalid);
   req.rready <= 1'b0;
endtask

// File: testbench/tb_dsp_router.sv
// routing core testbench

module tb_dsp_router import dsp_pkg::*; ();

   localparam int NS         = 8;
   localparam int NUM_TAPS   = NS + 4;          // slots, scope1, scope2, pwm0, pwm1
   localparam int MAX_CYCLES = 4000;            // about 4x the full sequence

   logic                 clk_i = 1'b0;
   logic                 rstn_i = 1'b0;
   sample_t              adc_a_i = '0;
   sample_t              adc_b_i = '0;
   sample_t              asg1_i = '0;
   sample_t              asg2_i = '0;
   sample_t [NS-1:0]     slot_signal_i = '0;
   sample_t [NS-1:0]     slot_direct_i = '0;
   axil_req_t            req = '0;
   sample_t              dac_a_o, dac_b_o, scope1_o, scope2_o, pwm0_o, pwm1_o;
   sample_t [NS-1:0]     slot_in_o;
   logic    [NS-1:0]     slot_sync_o;
   axil_rsp_t            rsp;

   // reference model state
   sel_t        m_sel [NUM_TAPS];
   dac_mask_t   m_mask [NS+2];
   logic [NS-1:0] m_sync;
   sample_t     exp_src [16];                   // indexed by source number
   sample_t     exp_tap [NUM_TAPS];
   sample_t     act_tap [NUM_TAPS];
   sample_t     direct_val [NS+2];
   int          sum_a, sum_b;
   int          pipe_a [5];                     // one entry per register stage
   int          pipe_b [5];
   sample_t     exp_dac_a, exp_dac_b;
   logic [31:0] exp_rdata = '0;
   logic [1:0]  exp_rresp = '0;
   logic [1:0]  exp_bresp = '0;
   int          errors = 0;
   int          cycles = 0;
   logic        stim_random = 1'b0;

   dsp_router_top #(.NUM_SLOTS(NS)) dsp_router_top_inst (
      .clk_i, .rstn_i, .adc_a_i, .adc_b_i, .asg1_i, .asg2_i,
      .slot_signal_i, .slot_direct_i,
      .axil_req_i (req),
      .dac_a_o, .dac_b_o, .scope1_o, .scope2_o, .pwm0_o, .pwm1_o,
      .slot_in_o, .slot_sync_o,
      .axil_rsp_o (rsp)
   );

   `include "tb_axil_tasks.svh"

   always #4 clk_i = ~clk_i;                    // 8 unit period

   task automatic report_mismatch(input string name, input int expv, input int actv);
      errors++;
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expv, actv);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("error at %0t: %s", $time, what);
   endtask

   function automatic string tap_name(input int t);
      case (t - NS)
         0:       return "scope1_o";
         1:       return "scope2_o";
         2:       return "pwm0_o";
         3:       return "pwm1_o";
         default: return $sformatf("slot_in_o[%0d]", t);
      endcase
   endfunction

   // new direct values, random or one level on all of them
   task automatic load_direct(input logic random_mode, input sample_t level);
      for (int k = 0; k < NS; k++) begin
         slot_direct_i[k] <= random_mode ? sample_t'($urandom) : level;
      end
      asg1_i <= random_mode ? sample_t'($urandom) : level;
      asg2_i <= random_mode ? sample_t'($urandom) : level;
   endtask

   // numbered sources, unused codes and none read zero
   always_comb begin
      for (int k = 0; k < 16; k++) begin
         exp_src[k] = '0;
      end
      for (int k = 0; k < NS; k++) begin
         exp_src[k] = slot_signal_i[k];
      end
      exp_src[NS]   = asg1_i;
      exp_src[NS+1] = asg2_i;
      exp_src[NS+2] = adc_a_i;
      exp_src[NS+3] = adc_b_i;
      exp_src[NS+4] = exp_dac_a;                // dac feedback, model side
      exp_src[NS+5] = exp_dac_b;
   end

   always_comb begin
      for (int k = 0; k < NUM_TAPS; k++) begin
         exp_tap[k] = exp_src[m_sel[k]];
      end
      for (int k = 0; k < NS; k++) begin
         act_tap[k] = slot_in_o[k];
      end
      act_tap[NS]   = scope1_o;
      act_tap[NS+1] = scope2_o;
      act_tap[NS+2] = pwm0_o;
      act_tap[NS+3] = pwm1_o;
   end

   // masked sums of the direct outputs
   always_comb begin
      for (int k = 0; k < NS; k++) begin
         direct_val[k] = slot_direct_i[k];
      end
      direct_val[NS]   = asg1_i;
      direct_val[NS+1] = asg2_i;
      sum_a = 0;
      sum_b = 0;
      for (int k = 0; k < NS + 2; k++) begin
         if (m_mask[k].to_dac_a) begin
            sum_a += int'(direct_val[k]);
         end
         if (m_mask[k].to_dac_b) begin
            sum_b += int'(direct_val[k]);
         end
      end
   end

   // five cycle latency to the dacs
   always @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < 5; k++) begin
            pipe_a[k] <= 0;
            pipe_b[k] <= 0;
         end
      end else begin
         pipe_a[0] <= sum_a;
         pipe_b[0] <= sum_b;
         for (int k = 1; k < 5; k++) begin
            pipe_a[k] <= pipe_a[k-1];
            pipe_b[k] <= pipe_b[k-1];
         end
      end
   end

   assign exp_dac_a = clamp_sample(pipe_a[4]);
   assign exp_dac_b = clamp_sample(pipe_b[4]);

   // fresh routed sources every cycle
   always @(posedge clk_i) begin
      if (stim_random) begin
         adc_a_i <= sample_t'($urandom);
         adc_b_i <= sample_t'($urandom);
         for (int k = 0; k < NS; k++) begin
            slot_signal_i[k] <= sample_t'($urandom);
         end
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("errors: %0d", errors);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   for (genvar t = 0; t < NUM_TAPS; t++) begin : g_tap_chk
      a_tap: assert property (@(posedge clk_i) disable iff (!rstn_i) act_tap[t] == exp_tap[t])
         else report_mismatch(tap_name(t), $sampled(exp_tap[t]), $sampled(act_tap[t]));
   end

   a_dac_a: assert property (@(posedge clk_i) disable iff (!rstn_i) dac_a_o == exp_dac_a)
      else report_mismatch("dac_a_o", $sampled(exp_dac_a), $sampled(dac_a_o));
   a_dac_b: assert property (@(posedge clk_i) disable iff (!rstn_i) dac_b_o == exp_dac_b)
      else report_mismatch("dac_b_o", $sampled(exp_dac_b), $sampled(dac_b_o));
   a_sync: assert property (@(posedge clk_i) disable iff (!rstn_i) slot_sync_o == m_sync)
      else report_mismatch("slot_sync_o", $sampled(m_sync), $sampled(slot_sync_o));

   // response payload at the handshake
   a_bresp: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.bvalid && req.bready |-> rsp.bresp == exp_bresp)
      else report_mismatch("bresp", $sampled(exp_bresp), $sampled(rsp.bresp));
   a_rresp: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.rvalid && req.rready |-> rsp.rresp == exp_rresp)
      else report_mismatch("rresp", $sampled(exp_rresp), $sampled(rsp.rresp));
   a_rdata: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.rvalid && req.rready |-> rsp.rdata == exp_rdata)
      else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rsp.rdata));

   // aw and w are taken in the same cycle
   a_wready: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.wready == rsp.awready)
      else report_failure("awready and wready did not pulse together");

   a_bhold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.bvalid && !req.bready |=> rsp.bvalid)
      else report_failure("bvalid dropped while bready was low");
   a_rhold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rsp.rvalid && !req.rready |=> rsp.rvalid)
      else report_failure("rvalid dropped while rready was low");

   initial begin
      void'($urandom(45));                      // one seed for the whole run
      for (int k = 0; k <= NS; k++) begin
         m_sel[k] <= sel_t'(NS + 2);            // slots and scope1 on adc a
      end
      m_sel[NS+1] <= sel_t'(NS + 3);
      m_sel[NS+2] <= SEL_NONE;
      m_sel[NS+3] <= SEL_NONE;
      for (int k = 0; k < NS + 2; k++) begin
         m_mask[k] <= '0;
      end
      m_sync <= '1;
      repeat (3) @(posedge clk_i);
      rstn_i      <= 1'b1;
      stim_random <= 1'b1;
      @(posedge clk_i);

      // reset values of the whole bank
      for (int t = 0; t < NUM_TAPS; t++) begin
         axil_read(reg_addr(t, REG_INPUT_SEL), 0);
      end
      for (int t = 0; t < NS + 2; t++) begin
         axil_read(reg_addr(t, REG_OUTPUT_SEL), 0);
      end
      axil_read(reg_addr(0, REG_SAT_STATUS), 0);
      axil_read(reg_addr(0, REG_SYNC), 0);

      // random routing, monitor reads
      for (int i = 0; i < 40; i++) begin
         axil_write(reg_addr($urandom_range(NUM_TAPS - 1), REG_INPUT_SEL),
                    32'($urandom_range(15)), 0);
         axil_read(reg_addr($urandom_range(NS + 5), REG_SIGNAL_MON), 0);
         repeat (2) @(posedge clk_i);
      end
      axil_write(reg_addr(0, REG_INPUT_SEL), 32'(NS + 4), 0);  // slot 0 hears dac a
      axil_write(reg_addr(NS, REG_INPUT_SEL), 32'(SEL_NONE), 0);

      // summation with random masks
      for (int r = 0; r < 10; r++) begin
         load_direct(1'b1, '0);
         for (int k = 0; k < NS + 2; k++) begin
            axil_write(reg_addr(k, REG_OUTPUT_SEL), 32'($urandom_range(3)), 0);
         end
         repeat (8) @(posedge clk_i);
      end

      // full scale, both directions
      load_direct(1'b0, sample_t'(8191));
      for (int k = 0; k < NS + 2; k++) begin
         axil_write(reg_addr(k, REG_OUTPUT_SEL), 32'd3, 0);
      end
      repeat (8) @(posedge clk_i);
      axil_read(reg_addr(0, REG_SAT_STATUS), 0);
      load_direct(1'b0, sample_t'(-8192));
      for (int k = 0; k < NS + 2; k++) begin
         axil_write(reg_addr(k, REG_OUTPUT_SEL), 32'd1, 0);  // dac a only
      end
      repeat (8) @(posedge clk_i);
      axil_read(reg_addr(0, REG_SAT_STATUS), 0);

      // bad addresses, stalls, sync
      axil_write(reg_addr(0, 16'h0014), 32'hF, 0);
      axil_write(reg_addr(NS + 5, REG_INPUT_SEL), 32'h3, 0);
      axil_write(reg_addr(NS + 2, REG_OUTPUT_SEL), 32'h3, 0);
      axil_read(reg_addr(0, 16'h0014), 0);
      axil_read(reg_addr(NS + 6, REG_SIGNAL_MON), 0);
      for (int t = 0; t < NUM_TAPS; t++) begin
         axil_read(reg_addr(t, REG_INPUT_SEL), 0);
      end
      axil_write(reg_addr(3, REG_SYNC), $urandom, 5);  // bready held low
      axil_read(reg_addr(0, REG_SYNC), 5);              // rready held low
      repeat (8) @(posedge clk_i);

      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
